// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W      16
`define REG_ADDR_W  3
`define NUM_REGS    8

// Major opcodes in instr[15:11]
`define OP_ADDIU    5'b01001
`define OP_ADDIU3   5'b01000
`define OP_RRR      5'b11100
`define OP_LOGIC    5'b11101
`define OP_SHIFT    5'b00110
`define OP_LI       5'b01101
`define OP_MOVE     5'b01111
`define OP_NOP      5'b00001

`define FN_ADDU     2'b01
`define FN_SUBU     2'b11
`define FN_SLL      2'b00
`define FN_SRL      2'b10
`define FN_SRA      2'b11
`define FN_AND      5'b01100    // Low five bits of imm8
`define FN_OR       5'b01101
`define FN_SRAV     5'b00111
`define FN_MFPC     8'b01000000 // Whole imm8

`endif

// File: cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	// Immediate format
	typedef struct packed {
		logic [4:0]             op;
		logic [`REG_ADDR_W-1:0] rx;
		logic [7:0]             imm8;
	} imm_fmt_t;

	// Register format
	typedef struct packed {
		logic [4:0]             op;
		logic [`REG_ADDR_W-1:0] rx;
		logic [`REG_ADDR_W-1:0] ry;
		logic [`REG_ADDR_W-1:0] rz; // Also shift amount
		logic [1:0]             fn;
	} reg_fmt_t;

	typedef union packed {
		imm_fmt_t imm_f;
		reg_fmt_t reg_f;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS
	} alu_op_e;

	// Second operand source
	typedef enum logic [2:0] {
		SRC_REG,
		SRC_SIMM8,
		SRC_SIMM4,
		SRC_SIMM5,
		SRC_ZIMM8,
		SRC_SHAMT3, // Zero encodes eight
		SRC_ZERO
	} opnd_src_e;

endpackage

// File: stage_if.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

// Decode to operand stage
interface dec_op_if;
	logic                   valid;
	cpu_pkg::instr_t        instr;
	logic [`DATA_W-1:0]     pc;
	logic [`DATA_W-1:0]     rval1;
	logic [`DATA_W-1:0]     rval2;
	logic [`REG_ADDR_W-1:0] src_a;   // Forwarding compare
	logic [`REG_ADDR_W-1:0] src_b;
	cpu_pkg::alu_op_e       alu_op;
	cpu_pkg::opnd_src_e     op2_src;
	logic                   op1_is_pc;
	logic                   wr_en;
	logic [`REG_ADDR_W-1:0] wr_addr;

	modport source (output valid, instr, pc, rval1, rval2, src_a, src_b,
		alu_op, op2_src, op1_is_pc, wr_en, wr_addr);
	modport sink (input valid, instr, pc, rval1, rval2, src_a, src_b,
		alu_op, op2_src, op1_is_pc, wr_en, wr_addr);
endinterface

// Operand to execute stage
interface op_ex_if;
	logic                   valid;
	logic [`DATA_W-1:0]     op1;
	logic [`DATA_W-1:0]     op2;
	cpu_pkg::alu_op_e       alu_op;
	logic                   wr_en;
	logic [`REG_ADDR_W-1:0] wr_addr;
	logic [`DATA_W-1:0]     alu_result; // Forward path back to operand

	modport source (output valid, op1, op2, alu_op, wr_en, wr_addr,
		input alu_result);
	modport sink (input valid, op1, op2, alu_op, wr_en, wr_addr,
		output alu_result);
endinterface

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] raddr1,
	input  logic [`REG_ADDR_W-1:0] raddr2,
	output logic [`DATA_W-1:0]     rdata1,
	output logic [`DATA_W-1:0]     rdata2,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] waddr,
	input  logic [`DATA_W-1:0]     wdata
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through so a same-cycle reader sees the new value
	assign rdata1 = (we && (waddr == raddr1)) ? wdata : regs[raddr1];
	assign rdata2 = (we && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	input  logic [`DATA_W-1:0]     pc,
	input  logic                   hold,
	input  logic                   flush,
	output logic [`REG_ADDR_W-1:0] rf_raddr1,
	output logic [`REG_ADDR_W-1:0] rf_raddr2,
	input  logic [`DATA_W-1:0]     rf_rdata1,
	input  logic [`DATA_W-1:0]     rf_rdata2,
	dec_op_if.source               dec
);

	logic               valid_q;
	cpu_pkg::instr_t    instr_q;
	logic [`DATA_W-1:0] pc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (flush) begin
			valid_q <= 1'b0; // Incoming word dropped too
		end else if (!hold) begin
			valid_q <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			instr_q <= instr;
			pc_q    <= pc;
		end
	end

	////////////////////////////////////////
	// Opcode classification
	////////////////////////////////////////
	always_comb begin
		dec.src_a     = instr_q.reg_f.rx;
		dec.src_b     = instr_q.reg_f.ry;
		dec.wr_addr   = instr_q.reg_f.rx;
		dec.alu_op    = cpu_pkg::ALU_ADD;
		dec.op2_src   = cpu_pkg::SRC_REG;
		dec.op1_is_pc = 1'b0;
		dec.wr_en     = 1'b0; // Unknown opcodes fall out as NOP
		case (instr_q.imm_f.op)
			`OP_ADDIU: begin
				dec.op2_src = cpu_pkg::SRC_SIMM8;
				dec.wr_en   = 1'b1;
			end
			`OP_ADDIU3: begin
				dec.op2_src = cpu_pkg::SRC_SIMM4;
				dec.wr_addr = instr_q.reg_f.ry;
				dec.wr_en   = 1'b1;
			end
			`OP_RRR: begin
				dec.wr_addr = instr_q.reg_f.rz;
				dec.alu_op  = (instr_q.reg_f.fn == `FN_SUBU) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
				dec.wr_en   = (instr_q.reg_f.fn == `FN_ADDU) || (instr_q.reg_f.fn == `FN_SUBU);
			end
			`OP_LOGIC: begin
				if (instr_q.imm_f.imm8 == `FN_MFPC) begin
					dec.op1_is_pc = 1'b1;
					dec.alu_op    = cpu_pkg::ALU_PASS;
					dec.wr_en     = 1'b1;
				end else begin
					case (instr_q.imm_f.imm8[4:0])
						`FN_AND: begin
							dec.alu_op = cpu_pkg::ALU_AND;
							dec.wr_en  = 1'b1;
						end
						`FN_OR: begin
							dec.alu_op = cpu_pkg::ALU_OR;
							dec.wr_en  = 1'b1;
						end
						`FN_SRAV: begin
							dec.src_a  = instr_q.reg_f.ry; // Value from ry, amount from rx
							dec.src_b  = instr_q.reg_f.rx;
							dec.alu_op = cpu_pkg::ALU_SRA;
							dec.wr_en  = 1'b1;
						end
						default: dec.wr_en = 1'b0;
					endcase
				end
			end
			`OP_SHIFT: begin
				dec.src_a   = instr_q.reg_f.ry;
				dec.op2_src = cpu_pkg::SRC_SHAMT3;
				dec.wr_en   = 1'b1;
				case (instr_q.reg_f.fn)
					`FN_SLL: dec.alu_op = cpu_pkg::ALU_SLL;
					`FN_SRL: dec.alu_op = cpu_pkg::ALU_SRL;
					`FN_SRA: dec.alu_op = cpu_pkg::ALU_SRA;
					default: dec.wr_en  = 1'b0;
				endcase
			end
			`OP_LI: begin
				dec.op2_src = cpu_pkg::SRC_ZIMM8;
				dec.wr_en   = 1'b1;
			end
			`OP_MOVE: begin
				dec.src_a   = instr_q.reg_f.ry;
				dec.op2_src = cpu_pkg::SRC_ZERO;
				dec.wr_en   = (instr_q.imm_f.imm8[4:0] == 5'b00000);
			end
			`OP_NOP: dec.wr_en = 1'b0;
			default: dec.wr_en = 1'b0;
		endcase
	end

	// Addresses come from the held word so reads refresh under hold
	assign rf_raddr1 = dec.src_a;
	assign rf_raddr2 = dec.src_b;

	assign dec.valid = valid_q;
	assign dec.instr = instr_q;
	assign dec.pc    = pc_q;
	assign dec.rval1 = rf_rdata1;
	assign dec.rval2 = rf_rdata2;

endmodule

// File: id_exe.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module id_exe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hold,
	input  logic                   flush,
	dec_op_if.sink                 dec,
	op_ex_if.source                ex,
	input  logic                   wb_valid,
	input  logic [`REG_ADDR_W-1:0] wb_addr,
	input  logic [`DATA_W-1:0]     wb_data
);

	logic [`DATA_W-1:0]     fwd_a;
	logic [`DATA_W-1:0]     fwd_b;
	logic [`DATA_W-1:0]     op1_d;
	logic [`DATA_W-1:0]     op2_d;
	logic [7:0]             imm8;
	logic [`REG_ADDR_W-1:0] shamt;

	////////////////////////////////////////
	// Forwarding
	////////////////////////////////////////
	assign fwd_a = (ex.valid && ex.wr_en && (ex.wr_addr == dec.src_a)) ? ex.alu_result :
		(wb_valid && (wb_addr == dec.src_a)) ? wb_data : dec.rval1;
	assign fwd_b = (ex.valid && ex.wr_en && (ex.wr_addr == dec.src_b)) ? ex.alu_result :
		(wb_valid && (wb_addr == dec.src_b)) ? wb_data : dec.rval2;

	assign imm8  = dec.instr.imm_f.imm8;
	assign shamt = dec.instr.reg_f.rz;

	always_comb begin
		if (dec.op1_is_pc) begin
			op1_d = dec.pc + 1'b1; // MFPC
		end else if (dec.op2_src == cpu_pkg::SRC_ZIMM8) begin
			op1_d = '0; // LI has no register operand
		end else begin
			op1_d = fwd_a;
		end
	end

	always_comb begin
		case (dec.op2_src)
			cpu_pkg::SRC_REG:    op2_d = fwd_b;
			cpu_pkg::SRC_SIMM8:  op2_d = {{(`DATA_W-8){imm8[7]}}, imm8};
			cpu_pkg::SRC_SIMM4:  op2_d = {{(`DATA_W-4){imm8[3]}}, imm8[3:0]};
			cpu_pkg::SRC_SIMM5:  op2_d = {{(`DATA_W-5){imm8[4]}}, imm8[4:0]};
			cpu_pkg::SRC_ZIMM8:  op2_d = {{(`DATA_W-8){1'b0}}, imm8};
			cpu_pkg::SRC_SHAMT3: begin
				op2_d = (shamt == '0) ? `DATA_W'(8) : {{(`DATA_W-3){1'b0}}, shamt};
			end
			default:             op2_d = '0;
		endcase
	end

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex.valid <= 1'b0;
		end else if (flush) begin
			ex.valid <= 1'b0; // Flush wins over hold
		end else if (!hold) begin
			ex.valid <= dec.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			ex.op1     <= op1_d;
			ex.op2     <= op2_d;
			ex.alu_op  <= dec.alu_op;
			ex.wr_en   <= dec.wr_en;
			ex.wr_addr <= dec.wr_addr;
		end
	end

endmodule

// File: exe_stage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exe_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hold,
	op_ex_if.sink                  ex,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`DATA_W-1:0]     wb_data
);

	logic [`DATA_W-1:0] result;
	logic [3:0]         shamt;

	assign shamt = ex.op2[3:0];

	always_comb begin
		case (ex.alu_op)
			cpu_pkg::ALU_ADD: result = ex.op1 + ex.op2;
			cpu_pkg::ALU_SUB: result = ex.op1 - ex.op2;
			cpu_pkg::ALU_AND: result = ex.op1 & ex.op2;
			cpu_pkg::ALU_OR:  result = ex.op1 | ex.op2;
			cpu_pkg::ALU_SLL: result = ex.op1 << shamt;
			cpu_pkg::ALU_SRL: result = ex.op1 >> shamt;
			cpu_pkg::ALU_SRA: result = $signed(ex.op1) >>> shamt;
			default:          result = ex.op1; // Pass
		endcase
	end

	assign ex.alu_result = result;

	// Hold inserts a bubble here while the operand item waits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex.valid && ex.wr_en && !hold;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= ex.wr_addr;
		wb_data <= result;
	end

endmodule

// File: datapath_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	input  logic [`DATA_W-1:0]     pc,
	input  logic                   hold,
	input  logic                   flush,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`DATA_W-1:0]     wb_data
);

	logic [`REG_ADDR_W-1:0] rf_raddr1;
	logic [`REG_ADDR_W-1:0] rf_raddr2;
	logic [`DATA_W-1:0]     rf_rdata1;
	logic [`DATA_W-1:0]     rf_rdata2;

	dec_op_if dec_op ();
	op_ex_if  op_ex ();

	reg_file reg_file_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (rf_raddr1),
		.raddr2 (rf_raddr2),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.we     (wb_valid),
		.waddr  (wb_addr),
		.wdata  (wb_data)
	);

	decode_stage decode_stage_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.hold        (hold),
		.flush       (flush),
		.rf_raddr1   (rf_raddr1),
		.rf_raddr2   (rf_raddr2),
		.rf_rdata1   (rf_rdata1),
		.rf_rdata2   (rf_rdata2),
		.dec         (dec_op.source)
	);

	id_exe id_exe_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.flush    (flush),
		.dec      (dec_op.sink),
		.ex       (op_ex.source),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	exe_stage exe_stage_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold     (hold),
		.ex       (op_ex.sink),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

endmodule

// File: tb_datapath.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_datapath;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND     = 40;
	localparam int N_CHAIN    = 12;
	localparam int N_HOLD     = 60;
	localparam int N_FLUSH    = 4;
	// Directed sections are counted as 40
	localparam int NUM_INSTR  = 40 + 3 * `NUM_REGS + N_RAND + 3 * N_CHAIN + N_HOLD + 5 * N_FLUSH;
	localparam int ENTRY_W    = `REG_ADDR_W + `DATA_W;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_valid;
	logic [`DATA_W-1:0]     instr;
	logic [`DATA_W-1:0]     pc;
	logic                   hold;
	logic                   flush;
	logic                   wb_valid;
	logic [`REG_ADDR_W-1:0] wb_addr;
	logic [`DATA_W-1:0]     wb_data;

	logic [`DATA_W-1:0]     model_regs [`NUM_REGS];
	logic [ENTRY_W-1:0]     exp_q [$]; // {addr, data}
	logic [ENTRY_W-1:0]     exp_item;
	logic [31:0]            rng_state;
	logic [`DATA_W-1:0]     pc_count;
	int                     errors;
	int                     wb_count;

	datapath_top datapath_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.hold        (hold),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [15:0] make_imm(input logic [4:0] op, input logic [2:0] rx,
		input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [15:0] make_reg(input logic [4:0] op, input logic [2:0] rx,
		input logic [2:0] ry, input logic [2:0] rz, input logic [1:0] fn);
		return {op, rx, ry, rz, fn};
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic void ref_exec(input logic [15:0] w, input logic [15:0] ipc);
		logic [4:0]         op;
		logic [2:0]         rx;
		logic [2:0]         ry;
		logic [2:0]         rz;
		logic [1:0]         fn;
		logic [7:0]         imm;
		logic [3:0]         sa;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] res;
		logic [2:0]         dst;
		logic               we;
		op  = w[15:11];
		rx  = w[10:8];
		ry  = w[7:5];
		rz  = w[4:2];
		fn  = w[1:0];
		imm = w[7:0];
		a   = model_regs[rx];
		b   = model_regs[ry];
		sa  = (rz == 3'd0) ? 4'd8 : {1'b0, rz};
		dst = rx;
		we  = 1'b1;
		res = '0;
		case (op)
			`OP_ADDIU:  res = a + {{(`DATA_W-8){imm[7]}}, imm};
			`OP_ADDIU3: begin
				dst = ry;
				res = a + {{(`DATA_W-4){imm[3]}}, imm[3:0]};
			end
			`OP_RRR: begin
				dst = rz;
				we  = (fn == `FN_ADDU) || (fn == `FN_SUBU);
				res = (fn == `FN_SUBU) ? a - b : a + b;
			end
			`OP_LOGIC: begin
				if (imm == `FN_MFPC) begin
					res = ipc + 16'd1;
				end else if (imm[4:0] == `FN_AND) begin
					res = a & b;
				end else if (imm[4:0] == `FN_OR) begin
					res = a | b;
				end else if (imm[4:0] == `FN_SRAV) begin
					res = $signed(b) >>> a[3:0]; // Value in ry, amount in rx
				end else begin
					we = 1'b0;
				end
			end
			`OP_SHIFT: begin
				case (fn)
					`FN_SLL: res = b << sa;
					`FN_SRL: res = b >> sa;
					`FN_SRA: res = $signed(b) >>> sa;
					default: we = 1'b0;
				endcase
			end
			`OP_LI:     res = {{(`DATA_W-8){1'b0}}, imm};
			`OP_MOVE: begin
				res = b;
				we  = (imm[4:0] == 5'b00000);
			end
			default:    we = 1'b0; // NOP and unsupported
		endcase
		if (we) begin
			model_regs[dst] = res;
			exp_q.push_back({dst, res});
		end
	endfunction

	function automatic logic [15:0] rand_instr(input logic [2:0] mask, input bit reg_ops_only);
		logic [31:0] r;
		logic [2:0]  rx;
		logic [2:0]  ry;
		logic [2:0]  rz;
		logic [7:0]  imm;
		int          kind;
		r    = next_rand();
		rx   = r[2:0] & mask;
		ry   = r[5:3] & mask;
		rz   = r[8:6] & mask;
		imm  = r[23:16];
		kind = reg_ops_only ? 2 + (r[31:24] % 5) : r[31:24] % 13;
		case (kind)
			0:       return make_imm(`OP_ADDIU, rx, imm);
			1:       return {`OP_ADDIU3, rx, ry, 1'b0, imm[3:0]};
			2:       return make_reg(`OP_RRR, rx, ry, rz, `FN_ADDU);
			3:       return make_reg(`OP_RRR, rx, ry, rz, `FN_SUBU);
			4:       return make_imm(`OP_LOGIC, rx, {ry, `FN_AND});
			5:       return make_imm(`OP_LOGIC, rx, {ry, `FN_OR});
			6:       return make_imm(`OP_LOGIC, rx, {ry, `FN_SRAV});
			7:       return make_reg(`OP_SHIFT, rx, ry, r[26:24], `FN_SLL);
			8:       return make_reg(`OP_SHIFT, rx, ry, r[26:24], `FN_SRL);
			9:       return make_reg(`OP_SHIFT, rx, ry, r[26:24], `FN_SRA);
			10:      return make_imm(`OP_LI, rx, imm);
			11:      return make_imm(`OP_MOVE, rx, {ry, 5'b00000});
			default: return make_imm(`OP_LOGIC, rx, `FN_MFPC);
		endcase
	endfunction

	////////////////////////////////////////
	// Drive tasks
	////////////////////////////////////////
	task automatic issue(input logic [15:0] w, input bit model_it);
		@(posedge clk);
		#2;
		instr_valid = 1'b1;
		instr       = w;
		pc          = pc_count;
		hold        = 1'b0;
		flush       = 1'b0;
		if (model_it) begin
			ref_exec(w, pc_count);
		end
		pc_count = pc_count + 16'd1;
	endtask

	task automatic idle(input bit hold_level);
		@(posedge clk);
		#2;
		instr_valid = 1'b0;
		instr       = '0;
		hold        = hold_level;
		flush       = 1'b0;
	endtask

	task automatic flush_with(input logic [15:0] w);
		@(posedge clk);
		#2;
		instr_valid = 1'b1; // Dropped along with the pipe
		instr       = w;
		pc          = pc_count;
		hold        = 1'b0;
		flush       = 1'b1;
		pc_count    = pc_count + 16'd1;
	endtask

	task automatic drain();
		int n;
		n = 0;
		idle(1'b0);
		while (exp_q.size() != 0 && n < 50) begin
			@(posedge clk);
			n++;
		end
		repeat (8) idle(1'b0);
	endtask

	// Compare writebacks in the middle of the cycle
	always @(negedge clk) begin
		if (rst_n && wb_valid === 1'b1) begin
			wb_count++;
			if (exp_q.size() == 0) begin
				$display("Unexpected writeback to r%0d with data %h", wb_addr, wb_data);
				errors++;
			end else begin
				exp_item = exp_q.pop_front();
				if (wb_addr !== exp_item[ENTRY_W-1:`DATA_W]) begin
					$display("Fail wb_addr: got %h, expected %h", wb_addr,
						exp_item[ENTRY_W-1:`DATA_W]);
					errors++;
				end
				if (wb_data !== exp_item[`DATA_W-1:0]) begin
					$display("Fail wb_data: got %h, expected %h", wb_data, exp_item[`DATA_W-1:0]);
					errors++;
				end
			end
		end
	end

	initial begin
		#(CLK_PERIOD * (NUM_INSTR * 10 + 200));
		$display("Timeout after %0d cycles, writebacks stopped arriving", NUM_INSTR * 10 + 200);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [2:0]  src;
		logic [2:0]  dst;
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		hold        = 1'b0;
		flush       = 1'b0;
		errors      = 0;
		wb_count    = 0;
		pc_count    = 16'h0100;
		rng_state   = 32'h780d_a1c1;
		for (int i = 0; i < `NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Zero registers after reset, then no-write forms
		issue(make_reg(`OP_RRR, 3'd0, 3'd1, 3'd2, `FN_ADDU), 1'b1);
		issue(make_imm(`OP_NOP, 3'd0, 8'h00), 1'b1);
		issue(make_imm(5'b10011, 3'd3, 8'h12), 1'b1);
		issue(make_imm(5'b00010, 3'd4, 8'hff), 1'b1);
		issue(make_reg(`OP_RRR, 3'd1, 3'd2, 3'd3, 2'b00), 1'b1);
		issue(make_imm(`OP_MOVE, 3'd5, 8'h23), 1'b1);
		issue(make_imm(`OP_LOGIC, 3'd6, 8'h1f), 1'b1);
		drain();

		////////////////////////////////////////
		// Immediate forms
		////////////////////////////////////////
		issue(make_imm(`OP_LI, 3'd1, 8'hf0), 1'b1);
		issue(make_imm(`OP_ADDIU, 3'd1, 8'h85), 1'b1);      // Negative
		issue({`OP_ADDIU3, 3'd1, 3'd2, 1'b0, 4'ha}, 1'b1);  // Negative
		issue({`OP_ADDIU3, 3'd2, 3'd3, 1'b0, 4'h5}, 1'b1);
		issue(make_imm(`OP_LI, 3'd3, 8'h81), 1'b1);
		issue(make_reg(`OP_SHIFT, 3'd3, 3'd3, 3'd0, `FN_SLL), 1'b1); // Shift by 8
		issue(make_reg(`OP_SHIFT, 3'd4, 3'd3, 3'd0, `FN_SRA), 1'b1);
		issue(make_reg(`OP_SHIFT, 3'd5, 3'd3, 3'd3, `FN_SRL), 1'b1);
		issue(make_reg(`OP_SHIFT, 3'd6, 3'd1, 3'd5, `FN_SLL), 1'b1);
		issue(make_reg(`OP_SHIFT, 3'd0, 3'd4, 3'd7, `FN_SRA), 1'b1);
		issue(make_imm(`OP_MOVE, 3'd7, {3'd4, 5'b00000}), 1'b1);
		issue(make_imm(`OP_LOGIC, 3'd2, `FN_MFPC), 1'b1);
		drain();

		// Load all registers with 16-bit values, then random register ops
		for (int i = 0; i < `NUM_REGS; i++) begin
			r = next_rand();
			issue(make_imm(`OP_LI, 3'(i), r[7:0]), 1'b1);
			issue(make_reg(`OP_SHIFT, 3'(i), 3'(i), 3'd0, `FN_SLL), 1'b1);
			issue(make_imm(`OP_ADDIU, 3'(i), r[15:8]), 1'b1);
		end
		for (int k = 0; k < N_RAND; k++) begin
			issue(rand_instr(3'b111, 1'b1), 1'b1);
		end
		drain();

		// Each instruction reads the result from d slots back
		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < N_CHAIN; k++) begin
				r   = next_rand();
				src = 3'(4 + ((k + 4 - d) % 4));
				dst = 3'(4 + (k % 4));
				issue(make_reg(`OP_RRR, src, r[2:0], dst, r[8] ? `FN_SUBU : `FN_ADDU), 1'b1);
			end
			drain();
		end

		////////////////////////////////////////
		// Hold pulses in a dependent stream
		////////////////////////////////////////
		for (int k = 0; k < N_HOLD; k++) begin
			r = next_rand();
			if (r[1:0] == 2'b00) begin
				idle(1'b1);
			end else begin
				issue(rand_instr(3'b011, 1'b0), 1'b1);
			end
		end
		drain();

		// Flush drops the decode item and the word presented with it
		for (int k = 0; k < N_FLUSH; k++) begin
			r = next_rand();
			issue(make_imm(`OP_ADDIU, 3'd4, r[7:0]), 1'b1);
			issue(make_imm(`OP_LI, 3'd5, r[15:8]), 1'b0);
			flush_with(make_imm(`OP_LI, 3'd6, r[23:16]));
			idle(1'b0);
			issue(make_reg(`OP_RRR, 3'd5, 3'd6, 3'd7, `FN_ADDU), 1'b1);
		end
		drain();

		if (exp_q.size() != 0) begin
			$display("%0d expected writebacks never arrived", exp_q.size());
			errors++;
		end
		$display("Compared %0d writebacks, %0d errors", wb_count, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+.
cpu_pkg.sv
stage_if.sv
reg_file.sv
decode_stage.sv
id_exe.sv
exe_stage.sv
datapath_top.sv
tb_datapath.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_datapath
FILELIST   = all.f
OBJ_DIR    = obj_dir
PASS_MSG   = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
